//--- bench/find_my_best_chk.sv
`timescale 1ns/1ns

module find_my_best_chk (
    input logic                  clock,
    input logic                  rst_n,
    input logic                  start,
    input logic                  done,
    input mybest_pkg::word_t     mybest,
    input mybest_pkg::read_tag_t read_tag
);

    int unsigned failures = 0;  // failed assertion count

    // done only follows an edge with start high
    done_needs_start: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(done) |-> $past(start))
    else begin
        failures++;
        $error("done rose while start was low");
    end

    result_held: assert property (@(posedge clock) disable iff (!rst_n)
        (done && start && $past(done && start)) |-> $stable(mybest))
    else begin
        failures++;
        $error("mybest changed while done and start were high");
    end

    // a returning word is either a q-value or the multiplier
    one_tag_only: assert property (@(posedge clock) disable iff (!rst_n)
        !(read_tag.q_valid && read_tag.hcm_valid))
    else begin
        failures++;
        $error("q and hcm read tags valid together");
    end

endmodule

bind find_my_best find_my_best_chk chk_i (
    .clock    (clock),
    .rst_n    (rst_n),
    .start    (start),
    .done     (done),
    .mybest   (mybest),
    .read_tag (read_tag)
);

//--- bench/find_my_best_tb.sv
`timescale 1ns/1ns

module find_my_best_tb;

    localparam int q_count        = 64;
    localparam int timeout_cycles = 200;
    localparam int abort_cycles   = 20;  // about a third into the q-table
    localparam int case_count     = 10;

    typedef logic [8*12-1:0] label_t;  // case name as packed text

    typedef enum logic [1:0] {
        fill_random,
        fill_max,     // q-values all 16'hFFFF and multipliers from the row
        fill_planted  // random with one small q-value at the row's index
    } fill_t;

    typedef enum logic [1:0] {
        expect_model,
        expect_saturated,
        expect_abort  // aborted run before a full rerun
    } expect_t;

    typedef struct packed {
        label_t               name;
        mybest_pkg::battery_t battery;
        fill_t                fill;
        logic [5:0]           index;
        mybest_pkg::word_t    value;
        expect_t              kind;
    } case_t;

    localparam case_t cases [case_count] = '{
        '{"rand_k0",      16'h0000, fill_random,  6'd0,  16'h0000, expect_model},
        '{"rand_k1",      16'h1999, fill_random,  6'd0,  16'h0000, expect_model},
        '{"rand_k5",      16'h8000, fill_random,  6'd0,  16'h0000, expect_model},
        '{"rand_k10",     16'hFFFF, fill_random,  6'd0,  16'h0000, expect_model},
        '{"plant_first",  16'h4000, fill_planted, 6'd0,  16'h0002, expect_model},
        '{"plant_last",   16'hC000, fill_planted, 6'd63, 16'h0001, expect_model},
        '{"max_unity",    16'h8000, fill_max,     6'd0,  16'h0100, expect_model},
        '{"max_saturate", 16'hFFFF, fill_max,     6'd0,  16'h0400, expect_saturated},
        '{"rand_again",   16'h2000, fill_random,  6'd0,  16'h0000, expect_model},
        '{"abort_rerun",  16'h3000, fill_random,  6'd5,  16'h0001, expect_abort}
    };

    logic                 clock = 1'b0;
    logic                 rst_n;
    logic                 start;
    mybest_pkg::battery_t battery;
    logic                 mem_write;
    mybest_pkg::addr_t    mem_addr;
    mybest_pkg::word_t    mem_data;
    mybest_pkg::word_t    mybest;
    logic                 done;

    logic [31:0]       lfsr_state = 32'h90aaf44d;
    mybest_pkg::word_t q_copy [q_count];
    mybest_pkg::word_t hcm_copy [mybest_pkg::hcm_length];

    find_my_best dut_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .start     (start),
        .battery   (battery),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_data  (mem_data),
        .mybest    (mybest),
        .done      (done)
    );

    always #50 clock = ~clock;

    // taps 32 22 2 1 with feedback into bit 0
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic mybest_pkg::word_t take_bits(input int count);
        mybest_pkg::word_t w;
        w = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[14:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic mybest_pkg::addr_t q_address(input int i);
        return mybest_pkg::addr_t'(int'(mybest_pkg::q_base) + 2 * i);
    endfunction

    function automatic mybest_pkg::addr_t hcm_address(input int k);
        return mybest_pkg::addr_t'(int'(mybest_pkg::hcm_base) + 2 * k);
    endfunction

    // expected mybest from the local table copy
    function automatic mybest_pkg::word_t model_best(input mybest_pkg::battery_t bat);
        mybest_pkg::word_t low;
        int                k;
        longint            product;
        low = 16'hFFFE;
        for (int i = 0; i < q_count; i++) begin
            if (q_copy[i] < low) begin
                low = q_copy[i];  // strictly smaller only
            end
        end
        k = (int'(bat) * 10 + 65535) / 65536;  // ceiling of 10 * battery
        if (k > 10) begin
            k = 10;
        end
        product = (longint'(low) * longint'(hcm_copy[k])) >> 8;
        if (product > 65535) begin
            return 16'hFFFF;
        end
        return mybest_pkg::word_t'(product);
    endfunction

    task automatic fail_run();
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_word(input label_t name, input mybest_pkg::word_t expected,
                              input mybest_pkg::word_t actual);
        assert (actual === expected) else begin
            $display("[ERROR] %0s: expected %h, actual %h", name, expected, actual);
            fail_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #5;
    endtask

    task automatic write_word(input mybest_pkg::addr_t addr, input mybest_pkg::word_t data);
        mem_write = 1'b1;
        mem_addr  = addr;
        mem_data  = data;
        next_cycle();
        mem_write = 1'b0;
    endtask

    task automatic wait_for_done(input logic level, input label_t name);
        int cycles;
        cycles = 0;
        while (done !== level && cycles < timeout_cycles) begin
            next_cycle();
            cycles++;
        end
        if (done !== level) begin
            $display("%0s: done did not go to %0b within %0d cycles", name, level,
                     timeout_cycles);
            fail_run();
        end
    endtask

    task automatic load_tables(input case_t c);
        mybest_pkg::word_t value;
        for (int i = 0; i < q_count; i++) begin
            if (c.fill == fill_max) begin
                value = 16'hFFFF;
            end else begin
                value = take_bits(16);
            end
            if (c.fill == fill_planted && i == int'(c.index)) begin
                value = c.value;
            end
            q_copy[i] = value;
            write_word(q_address(i), value);
        end
        for (int k = 0; k < mybest_pkg::hcm_length; k++) begin
            if (c.fill == fill_max) begin
                value = c.value;
            end else begin
                value = take_bits(12);  // multipliers below 16.0
            end
            hcm_copy[k] = value;
            write_word(hcm_address(k), value);
        end
    endtask

    task automatic run_case(input case_t c);
        mybest_pkg::word_t expected;
        load_tables(c);
        battery = c.battery;
        if (c.kind == expect_abort) begin
            start = 1'b1;
            repeat (abort_cycles) next_cycle();
            start = 1'b0;
            next_cycle();
            wait_for_done(1'b0, c.name);
            q_copy[c.index] = c.value;  // new minimum between the runs
            write_word(q_address(int'(c.index)), c.value);
        end
        expected = model_best(c.battery);
        start = 1'b1;
        wait_for_done(1'b1, c.name);
        check_word(c.name, expected, mybest);
        if (c.kind == expect_saturated) begin
            check_word(c.name, 16'hFFFF, mybest);
        end
        repeat (4) next_cycle();
        check_word(c.name, expected, mybest);  // held while start stays high
        start = 1'b0;
        wait_for_done(1'b0, c.name);
    endtask

    // a bound assertion failure ends the run at once
    always @(posedge clock) begin
        if (dut_i.chk_i.failures != 0) begin
            $display("a bound assertion failed");
            fail_run();
        end
    end

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        battery   = '0;
        mem_write = 1'b0;
        mem_addr  = '0;
        mem_data  = '0;
        repeat (16) @(posedge clock);
        #5;
        rst_n = 1'b1;
        next_cycle();
        check_word("after_reset", 16'hFFFE, mybest);
        assert (done === 1'b0) else begin
            $display("[ERROR] after_reset: expected done 0, actual %b", done);
            fail_run();
        end
        for (int i = 0; i < case_count; i++) begin
            run_case(cases[i]);
        end
        if (dut_i.chk_i.failures == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("bound assertions failed %0d times", dut_i.chk_i.failures);
            fail_run();
        end
    end

endmodule

//--- project.f
source/mybest_pkg.sv
source/node_memory.sv
source/scan_sequencer.sv
source/min_tracker.sv
source/cost_multiplier.sv
source/find_my_best.sv
bench/find_my_best_chk.sv
bench/find_my_best_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module find_my_best_tb -f project.f \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vfind_my_best_tb +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qx "ALL CHECKS PASSED" && echo "run passed" \
    || { echo "run failed"; exit 1; }

//--- source/cost_multiplier.sv
`timescale 1ns/1ns

module cost_multiplier (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   hcm_valid,
    input  mybest_pkg::word_t      min_cost,
    input  mybest_pkg::word_t      hcm_word,
    output mybest_pkg::best_cost_t best
);

    logic [31:0]       product;
    mybest_pkg::word_t scaled;

    // q8.8 times q8.8 gives q16.16, keep the middle 16 bits
    assign product = min_cost * hcm_word;

    always_comb begin
        if (|product[31:24]) begin
            scaled = '1;  // saturate
        end else begin
            scaled = product[23:8];
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            best.mybest <= mybest_pkg::mybest_init;
            best.done   <= 1'b0;
        end else if (!start) begin
            best.done <= 1'b0;  // mybest keeps its last value
        end else if (hcm_valid) begin
            best.mybest <= scaled;
            best.done   <= 1'b1;
        end
    end

endmodule

//--- source/find_my_best.sv
`timescale 1ns/1ns

module find_my_best (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 start,
    input  mybest_pkg::battery_t battery,
    input  logic                 mem_write,
    input  mybest_pkg::addr_t    mem_addr,
    input  mybest_pkg::word_t    mem_data,
    output mybest_pkg::word_t    mybest,
    output logic                 done
);

    mybest_pkg::addr_t      read_addr;
    mybest_pkg::word_t      read_data;
    mybest_pkg::read_tag_t  read_tag;  // aligned with read_data
    mybest_pkg::word_t      min_cost;
    mybest_pkg::best_cost_t best;
    logic                   clear;

    node_memory memory_i (
        .clock      (clock),
        .write      (mem_write),
        .write_addr (mem_addr),
        .read_addr  (read_addr),
        .write_data (mem_data),
        .read_data  (read_data)
    );

    scan_sequencer sequencer_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .start     (start),
        .battery   (battery),
        .read_addr (read_addr),
        .read_tag  (read_tag),
        .clear     (clear)
    );

    min_tracker tracker_i (
        .clock    (clock),
        .rst_n    (rst_n),
        .clear    (clear),
        .q_valid  (read_tag.q_valid),
        .data     (read_data),
        .min_cost (min_cost)
    );

    cost_multiplier multiplier_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .start     (start),
        .hcm_valid (read_tag.hcm_valid),
        .min_cost  (min_cost),
        .hcm_word  (read_data),
        .best      (best)
    );

    assign mybest = best.mybest;
    assign done   = best.done;

endmodule

//--- source/min_tracker.sv
`timescale 1ns/1ns

module min_tracker (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              clear,
    input  logic              q_valid,
    input  mybest_pkg::word_t data,
    output mybest_pkg::word_t min_cost
);

    logic smaller;

    // strict compare, equal entries keep the old minimum
    assign smaller = data < min_cost;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            min_cost <= mybest_pkg::mybest_init;
        end else if (clear) begin
            min_cost <= mybest_pkg::mybest_init;  // new run
        end else if (q_valid && smaller) begin
            min_cost <= data;
        end
    end

endmodule

//--- source/mybest_pkg.sv
package mybest_pkg;

    typedef logic [15:0] word_t;       // q8.8 cost, multiplier or product
    typedef logic [11:0] addr_t;       // byte address into node memory
    typedef logic [15:0] battery_t;    // q0.16 charge fraction
    typedef logic [3:0]  hcm_index_t;  // 0 to 10

    // node memory layout, byte addresses with one word per even address
    localparam addr_t q_base   = 12'h1C8;  // first q-value
    localparam addr_t q_last   = 12'h246;  // last q-value, 64 entries
    localparam addr_t hcm_base = 12'h648;  // charge multiplier table

    localparam int hcm_length = 11;

    localparam word_t mybest_init = 16'hFFFE;  // starting minimum

    localparam int mem_words   = 1024;
    localparam int mem_index_w = $clog2(mem_words);  // word index bits

    typedef enum logic [2:0] {
        idle,       // waiting for start
        scan_q,     // one q read per cycle
        fetch_hcm,  // latch hcm index from battery
        wait_hcm,   // hcm read issued
        finished    // result held until start drops
    } scan_state_t;

    // travels with each read so the returning word can be told apart
    typedef struct packed {
        logic q_valid;    // word is a q-value
        logic hcm_valid;  // word is the selected multiplier
    } read_tag_t;

    typedef struct packed {
        word_t mybest;  // scaled best cost
        logic  done;    // result valid
    } best_cost_t;

endpackage

//--- source/node_memory.sv
`timescale 1ns/1ns

module node_memory (
    input  logic              clock,
    input  logic              write,
    input  mybest_pkg::addr_t write_addr,
    input  mybest_pkg::addr_t read_addr,
    input  mybest_pkg::word_t write_data,
    output mybest_pkg::word_t read_data
);

    mybest_pkg::word_t mem [mybest_pkg::mem_words];

    logic [mybest_pkg::mem_index_w-1:0] write_index;
    logic [mybest_pkg::mem_index_w-1:0] read_index;

    // byte address to word index, bit 0 is the byte within the word
    assign write_index = write_addr[mybest_pkg::mem_index_w:1];
    assign read_index  = read_addr[mybest_pkg::mem_index_w:1];

    always_ff @(posedge clock) begin
        if (write) begin
            mem[write_index] <= write_data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clock) begin
        read_data <= mem[read_index];
    end

endmodule

//--- source/scan_sequencer.sv
`timescale 1ns/1ns

module scan_sequencer (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  start,
    input  mybest_pkg::battery_t  battery,
    output mybest_pkg::addr_t     read_addr,
    output mybest_pkg::read_tag_t read_tag,
    output logic                  clear
);

    mybest_pkg::scan_state_t state;
    mybest_pkg::addr_t       q_addr;
    mybest_pkg::hcm_index_t  hcm_index;
    mybest_pkg::hcm_index_t  index_calc;
    mybest_pkg::read_tag_t   issue_tag;
    logic [19:0]             battery_x10;
    logic                    has_fraction;

    // k = ceil(10 * battery), battery is q0.16
    assign battery_x10  = 20'(battery) * 20'd10;
    assign has_fraction = |battery_x10[15:0];  // round up on any remainder

    always_comb begin
        index_calc = battery_x10[19:16] + mybest_pkg::hcm_index_t'(has_fraction);
        if (index_calc >= mybest_pkg::hcm_index_t'(mybest_pkg::hcm_length)) begin
            index_calc = mybest_pkg::hcm_index_t'(mybest_pkg::hcm_length - 1);
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state  <= mybest_pkg::idle;
            q_addr <= mybest_pkg::q_base;
        end else if (!start) begin
            state <= mybest_pkg::idle;  // level start, dropping it aborts
        end else begin
            case (state)
                mybest_pkg::idle: begin
                    state  <= mybest_pkg::scan_q;
                    q_addr <= mybest_pkg::q_base;
                end
                mybest_pkg::scan_q: begin
                    if (q_addr == mybest_pkg::q_last) begin
                        state <= mybest_pkg::fetch_hcm;
                    end else begin
                        q_addr <= q_addr + 12'd2;  // next word
                    end
                end
                mybest_pkg::fetch_hcm: begin
                    state <= mybest_pkg::wait_hcm;
                end
                mybest_pkg::wait_hcm: begin
                    state <= mybest_pkg::finished;
                end
                mybest_pkg::finished: begin
                    state <= mybest_pkg::finished;  // hold until start low
                end
                default: begin
                    state <= mybest_pkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == mybest_pkg::fetch_hcm) begin
            hcm_index <= index_calc;
        end
    end

    always_comb begin
        issue_tag = '0;
        read_addr = q_addr;
        case (state)
            mybest_pkg::scan_q: begin
                issue_tag.q_valid = start;
            end
            mybest_pkg::wait_hcm: begin
                read_addr           = mybest_pkg::hcm_base + mybest_pkg::addr_t'({hcm_index, 1'b0});
                issue_tag.hcm_valid = start;
            end
            default: begin
                issue_tag = '0;
            end
        endcase
    end

    // tag follows the memory by one cycle
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            read_tag <= '0;
        end else begin
            read_tag <= issue_tag;
        end
    end

    assign clear = (state == mybest_pkg::idle) && start;  // first edge of a run

endmodule
